/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scoreboard
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

/* fu_pkg.sv */
`include "sb_params.svh"

package fu_pkg;

    typedef logic [$clog2(`SB_NUM_FU)-1:0] fu_id_t;

    // One bit per functional unit
    typedef logic [`SB_NUM_FU-1:0] fu_mask_t;

    typedef logic [`SB_REG_BIT-1:0] data_t;

endpackage

/* issue_rename.sv */
`include "sb_params.svh"

module issue_rename (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  fu_pkg::fu_mask_t                           fu_available,
    input  logic                                       issue_vld,
    output logic                                       issue_rdy,
    input  fu_pkg::fu_id_t                             issue_fu,
    input  rename_pkg::tag_id_t                        issue_dst_reg,
    input  rename_pkg::tag_id_t                        issue_src_reg0,
    input  rename_pkg::tag_id_t                        issue_src_reg1,
    output rename_pkg::reg_id_t                        issue_dst_reg_rename,
    output rename_pkg::reg_id_t                        issue_src_reg0_rename,
    output rename_pkg::reg_id_t                        issue_src_reg1_rename,
    input  rename_pkg::reg_id_t                        free_reg,
    input  logic                                       free_any,
    output logic                                       alloc_en,
    output rename_pkg::reg_id_t                        old_dst_reg,
    output rename_pkg::reg_id_t [`SB_NUM_TAG-1:0]      cur_tag_map
);

    // Current physical register behind each architectural tag
    rename_pkg::reg_id_t [`SB_NUM_TAG-1:0] tag_map;

    logic dst_used;

    // Tag 0 means the instruction produces no value
    assign dst_used = (issue_dst_reg != '0);

    // A destination-less instruction only needs its FU
    assign issue_rdy = fu_available[issue_fu] && (!dst_used || free_any);

    assign alloc_en = issue_vld && issue_rdy && dst_used;

    // The mapping that the new allocation replaces
    assign old_dst_reg = tag_map[issue_dst_reg];

    assign issue_dst_reg_rename  = dst_used ? free_reg : '0;
    assign issue_src_reg0_rename = tag_map[issue_src_reg0];
    assign issue_src_reg1_rename = tag_map[issue_src_reg1];

    assign cur_tag_map = tag_map;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_map <= '0;
        end else if (alloc_en) begin
            tag_map[issue_dst_reg] <= free_reg;
        end
    end

endmodule

/* read_gate.sv */
`include "sb_params.svh"

module read_gate (
    input  rename_pkg::reg_mask_t                 reg_write_pending,
    input  fu_pkg::fu_mask_t                      fu_read_vld,
    output fu_pkg::fu_mask_t                      fu_read_rdy,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_read_reg0,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_read_reg1,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_write_reg_nxt,
    output fu_pkg::fu_mask_t                      rf_read_vld,
    input  fu_pkg::fu_mask_t                      rf_read_rdy,
    output rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  rf_read_reg0,
    output rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  rf_read_reg1
);

    fu_pkg::fu_mask_t src0_ok;
    fu_pkg::fu_mask_t src1_ok;
    fu_pkg::fu_mask_t hazard_free;

    // A source that is also the FU's own next destination is still readable,
    // as in r3 = r3 + r2, because renaming never hands a pending register to
    // another FU
    for (genvar f = 0; f < `SB_NUM_FU; f++) begin : gen_fu
        assign src0_ok[f] = !reg_write_pending[fu_read_reg0[f]] ||
                            (fu_read_reg0[f] == fu_write_reg_nxt[f]);
        assign src1_ok[f] = !reg_write_pending[fu_read_reg1[f]] ||
                            (fu_read_reg1[f] == fu_write_reg_nxt[f]);
    end

    assign hazard_free = src0_ok & src1_ok;

    // Both directions of the handshake are held while a hazard exists
    assign rf_read_vld = fu_read_vld & hazard_free;
    assign fu_read_rdy = rf_read_rdy & hazard_free;

    assign rf_read_reg0 = fu_read_reg0;
    assign rf_read_reg1 = fu_read_reg1;

endmodule

/* reg_status.sv */
`include "sb_params.svh"

module reg_status (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rename_pkg::reg_mask_t reg_read_pending,
    input  logic                  alloc_en,
    input  rename_pkg::reg_id_t   old_dst_reg,
    input  rename_pkg::reg_mask_t wb_mask,
    output rename_pkg::reg_mask_t reg_write_pending,
    output rename_pkg::reg_id_t   free_reg,
    output logic                  free_any
);

    rename_pkg::reg_mask_t retired;

    // Decoded forms of the register being allocated and the one being replaced
    rename_pkg::reg_mask_t alloc_mask;
    rename_pkg::reg_mask_t old_mask;
    rename_pkg::reg_mask_t retire_mask;

    rename_pkg::reg_mask_t free_vec;

    assign alloc_mask = alloc_en ? (rename_pkg::reg_mask_t'(1) << free_reg) : '0;

    // Not gated by alloc_en, since the free test below feeds issue_rdy and
    // therefore alloc_en itself
    assign old_mask = rename_pkg::reg_mask_t'(1) << old_dst_reg;

    assign retire_mask = alloc_en ? old_mask : '0;

    // The register that the destination tag maps to right now can be reused
    // for the same tag, as nobody else can name it after this issue
    always_comb begin
        free_vec    = ~reg_read_pending & ~reg_write_pending & (retired | old_mask);
        free_vec[0] = 1'b0;
    end

    assign free_any = |free_vec;

    // Lowest-numbered free register wins
    always_comb begin
        free_reg = '0;
        for (int r = `SB_NUM_REG - 1; r > 0; r--) begin
            if (free_vec[r]) begin
                free_reg = rename_pkg::reg_id_t'(r);
            end
        end
    end

    // A new allocation takes priority over a write-back to the same register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_write_pending <= '0;
        end else begin
            reg_write_pending <= (reg_write_pending & ~wb_mask) | alloc_mask;
        end
    end

    // Allocation clears the retired bit even when the allocated register is
    // also the one being replaced
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired <= '1;
        end else begin
            retired <= (retired | retire_mask) & ~alloc_mask;
        end
    end

endmodule

/* rename_pkg.sv */
`include "sb_params.svh"

package rename_pkg;

    // Architectural tag number as seen by the issue stage
    typedef logic [$clog2(`SB_NUM_TAG)-1:0] tag_id_t;

    // Physical register number after renaming
    typedef logic [$clog2(`SB_NUM_REG)-1:0] reg_id_t;

    // One bit per physical register
    typedef logic [`SB_NUM_REG-1:0] reg_mask_t;

endpackage

/* sb_params.svh */
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// Physical registers, register 0 is reserved as "no register"
`define SB_NUM_REG 8

// Architectural tags, tag 0 is reserved as "no tag"
`define SB_NUM_TAG 4

`define SB_NUM_FU 4

`define SB_REG_BIT 16

`endif

/* scoreboard_top.sv */
`include "sb_params.svh"

module scoreboard_top (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  fu_pkg::fu_mask_t                      fu_available,
    input  rename_pkg::reg_mask_t                 reg_read_pending,
    output rename_pkg::reg_mask_t                 reg_write_pending,
    output rename_pkg::reg_id_t [`SB_NUM_TAG-1:0] cur_tag_map,

    // Issue channel, one instruction per cycle
    input  logic                                  issue_vld,
    output logic                                  issue_rdy,
    input  fu_pkg::fu_id_t                        issue_fu,
    input  rename_pkg::tag_id_t                   issue_dst_reg,
    input  rename_pkg::tag_id_t                   issue_src_reg0,
    input  rename_pkg::tag_id_t                   issue_src_reg1,
    output rename_pkg::reg_id_t                   issue_dst_reg_rename,
    output rename_pkg::reg_id_t                   issue_src_reg0_rename,
    output rename_pkg::reg_id_t                   issue_src_reg1_rename,

    // FU reads toward the register file
    input  fu_pkg::fu_mask_t                      fu_read_vld,
    output fu_pkg::fu_mask_t                      fu_read_rdy,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_read_reg0,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_read_reg1,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_write_reg_nxt,
    output fu_pkg::fu_mask_t                      rf_read_vld,
    input  fu_pkg::fu_mask_t                      rf_read_rdy,
    output rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  rf_read_reg0,
    output rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  rf_read_reg1,

    // FU write-backs toward the register file
    input  fu_pkg::fu_mask_t                      fu_write_vld,
    output fu_pkg::fu_mask_t                      fu_write_rdy,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_write_reg,
    input  fu_pkg::data_t [`SB_NUM_FU-1:0]        fu_write_data,
    output fu_pkg::fu_mask_t                      rf_write_vld,
    input  fu_pkg::fu_mask_t                      rf_write_rdy,
    output rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  rf_write_reg,
    output fu_pkg::data_t [`SB_NUM_FU-1:0]        rf_write_data
);

    rename_pkg::reg_id_t   free_reg;
    logic                  free_any;
    logic                  alloc_en;
    rename_pkg::reg_id_t   old_dst_reg;
    rename_pkg::reg_mask_t wb_mask;

    issue_rename issue_rename_inst (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .fu_available          (fu_available),
        .issue_vld             (issue_vld),
        .issue_rdy             (issue_rdy),
        .issue_fu              (issue_fu),
        .issue_dst_reg         (issue_dst_reg),
        .issue_src_reg0        (issue_src_reg0),
        .issue_src_reg1        (issue_src_reg1),
        .issue_dst_reg_rename  (issue_dst_reg_rename),
        .issue_src_reg0_rename (issue_src_reg0_rename),
        .issue_src_reg1_rename (issue_src_reg1_rename),
        .free_reg              (free_reg),
        .free_any              (free_any),
        .alloc_en              (alloc_en),
        .old_dst_reg           (old_dst_reg),
        .cur_tag_map           (cur_tag_map)
    );

    reg_status reg_status_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .reg_read_pending  (reg_read_pending),
        .alloc_en          (alloc_en),
        .old_dst_reg       (old_dst_reg),
        .wb_mask           (wb_mask),
        .reg_write_pending (reg_write_pending),
        .free_reg          (free_reg),
        .free_any          (free_any)
    );

    read_gate read_gate_inst (
        .reg_write_pending (reg_write_pending),
        .fu_read_vld       (fu_read_vld),
        .fu_read_rdy       (fu_read_rdy),
        .fu_read_reg0      (fu_read_reg0),
        .fu_read_reg1      (fu_read_reg1),
        .fu_write_reg_nxt  (fu_write_reg_nxt),
        .rf_read_vld       (rf_read_vld),
        .rf_read_rdy       (rf_read_rdy),
        .rf_read_reg0      (rf_read_reg0),
        .rf_read_reg1      (rf_read_reg1)
    );

    write_back write_back_inst (
        .fu_write_vld  (fu_write_vld),
        .fu_write_rdy  (fu_write_rdy),
        .fu_write_reg  (fu_write_reg),
        .fu_write_data (fu_write_data),
        .rf_write_vld  (rf_write_vld),
        .rf_write_rdy  (rf_write_rdy),
        .rf_write_reg  (rf_write_reg),
        .rf_write_data (rf_write_data),
        .wb_mask       (wb_mask)
    );

endmodule

/* sim.f */
+incdir+.
rename_pkg.sv
fu_pkg.sv
issue_rename.sv
reg_status.sv
read_gate.sv
write_back.sv
scoreboard_top.sv
tb_scoreboard.sv

/* tb_scoreboard.sv */
`include "sb_params.svh"

module tb_scoreboard;

    localparam int TIMEOUT = 20;

    logic clk = 1'b0;
    logic rst_n;

    fu_pkg::fu_mask_t                      fu_available;
    rename_pkg::reg_mask_t                 reg_read_pending;
    rename_pkg::reg_mask_t                 reg_write_pending;
    rename_pkg::reg_id_t [`SB_NUM_TAG-1:0] cur_tag_map;

    logic                issue_vld, issue_rdy;
    fu_pkg::fu_id_t      issue_fu;
    rename_pkg::tag_id_t issue_dst_reg, issue_src_reg0, issue_src_reg1;
    rename_pkg::reg_id_t issue_dst_reg_rename, issue_src_reg0_rename, issue_src_reg1_rename;

    fu_pkg::fu_mask_t                     fu_read_vld, fu_read_rdy, rf_read_vld, rf_read_rdy;
    rename_pkg::reg_id_t [`SB_NUM_FU-1:0] fu_read_reg0, fu_read_reg1, fu_write_reg_nxt;
    rename_pkg::reg_id_t [`SB_NUM_FU-1:0] rf_read_reg0, rf_read_reg1;

    fu_pkg::fu_mask_t                     fu_write_vld, fu_write_rdy, rf_write_vld, rf_write_rdy;
    rename_pkg::reg_id_t [`SB_NUM_FU-1:0] fu_write_reg, rf_write_reg;
    fu_pkg::data_t [`SB_NUM_FU-1:0]       fu_write_data, rf_write_data;

    // Reference copy of the rename map and the per-register state
    rename_pkg::reg_id_t   m_map [`SB_NUM_TAG];
    rename_pkg::reg_mask_t m_pending;
    rename_pkg::reg_mask_t m_retired;

    string               test_name = "reset";
    int                  errors = 0;
    int                  fwd_errors = 0;
    int                  alloc_errors = 0;
    int                  checks = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  test_start_errors = 0;
    int unsigned         rand_init;
    rename_pkg::reg_id_t got;
    int                  waited;

    scoreboard_top scoreboard_top_inst (.*);

    always #20 clk = ~clk;

    initial begin
        #200000;
        $display("Simulation time limit reached before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    // Both register file channels are pure pass-through, reads only gated
    fwd_check: assert property (@(posedge clk) disable iff (!rst_n)
        rf_write_vld == fu_write_vld && fu_write_rdy == rf_write_rdy &&
        rf_write_reg == fu_write_reg && rf_write_data == fu_write_data &&
        rf_read_reg0 == fu_read_reg0 && rf_read_reg1 == fu_read_reg1 &&
        (rf_read_vld & ~fu_read_vld) == '0)
        else begin
            $display("%s: register file channel not forwarded unchanged at %0t", test_name, $time);
            fwd_errors++;
        end

    // An accepted issue never gets register 0 or a register that is still in use
    alloc_check: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_vld && issue_rdy && issue_dst_reg != '0) |->
        (issue_dst_reg_rename != '0 && !reg_write_pending[issue_dst_reg_rename] &&
         !reg_read_pending[issue_dst_reg_rename]))
        else begin
            $display("%s: busy register %0d allocated at %0t", test_name,
                     issue_dst_reg_rename, $time);
            alloc_errors++;
        end

    function automatic int total_errors();
        return errors + fwd_errors + alloc_errors;
    endfunction

    // Registers that may take a new value for destination tag dst
    function automatic rename_pkg::reg_mask_t model_free_mask(input rename_pkg::tag_id_t dst);
        rename_pkg::reg_mask_t mask;
        mask = '0;
        for (int r = 1; r < `SB_NUM_REG; r++) begin
            mask[r] = !reg_read_pending[r] && !m_pending[r] &&
                      (m_retired[r] || m_map[dst] == rename_pkg::reg_id_t'(r));
        end
        return mask;
    endfunction

    function automatic rename_pkg::reg_id_t model_lowest(input rename_pkg::reg_mask_t mask);
        rename_pkg::reg_id_t pick;
        pick = '0;
        for (int r = 1; r < `SB_NUM_REG; r++) begin
            if (mask[r] && pick == '0) begin
                pick = rename_pkg::reg_id_t'(r);
            end
        end
        return pick;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act == exp) else begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_state();
        for (int t = 0; t < `SB_NUM_TAG; t++) begin
            check_value($sformatf("cur_tag_map[%0d]", t), 32'(m_map[t]), 32'(cur_tag_map[t]));
        end
        check_value("reg_write_pending", 32'(m_pending), 32'(reg_write_pending));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = total_errors();
        tests_run++;
    endtask

    task automatic finish_test();
        int new_errors;
        new_errors = total_errors() - test_start_errors;
        if (new_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, new_errors);
            tests_failed++;
        end
    endtask

    // Looks at issue_rdy without offering an instruction
    task automatic probe_issue(input fu_pkg::fu_id_t fu, input rename_pkg::tag_id_t dst);
        logic exp_rdy;
        issue_vld     = 1'b0;
        issue_fu      = fu;
        issue_dst_reg = dst;
        #1;
        exp_rdy = fu_available[fu] && (dst == '0 || model_free_mask(dst) != '0);
        check_value($sformatf("issue_rdy fu %0d dst %0d", fu, dst), 32'(exp_rdy), 32'(issue_rdy));
    endtask

    task automatic issue_instr(input fu_pkg::fu_id_t fu, input rename_pkg::tag_id_t dst,
                               output rename_pkg::reg_id_t dst_reg);
        rename_pkg::tag_id_t src0;
        rename_pkg::tag_id_t src1;
        rename_pkg::reg_id_t exp_dst;
        int                  cycles;
        src0           = rename_pkg::tag_id_t'($urandom % `SB_NUM_TAG);
        src1           = rename_pkg::tag_id_t'($urandom % `SB_NUM_TAG);
        issue_fu       = fu;
        issue_dst_reg  = dst;
        issue_src_reg0 = src0;
        issue_src_reg1 = src1;
        issue_vld      = 1'b1;
        #1;
        cycles = 0;
        while (!issue_rdy && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        assert (issue_rdy) else begin
            $display("%s: issue_rdy stayed low for %0d cycles on FU %0d", test_name, TIMEOUT, fu);
            errors++;
        end
        dst_reg = issue_dst_reg_rename;
        if (issue_rdy) begin
            exp_dst = (dst == '0) ? '0 : model_lowest(model_free_mask(dst));
            check_value("issue_dst_reg_rename", 32'(exp_dst), 32'(issue_dst_reg_rename));
            check_value("issue_src_reg0_rename", 32'(m_map[src0]), 32'(issue_src_reg0_rename));
            check_value("issue_src_reg1_rename", 32'(m_map[src1]), 32'(issue_src_reg1_rename));
            @(posedge clk);
            if (dst != '0) begin
                // The replaced register retires, the new one becomes pending
                m_retired[m_map[dst]] = 1'b1;
                m_retired[exp_dst]    = 1'b0;
                m_pending[exp_dst]    = 1'b1;
                m_map[dst]            = exp_dst;
            end
            #2;
        end
        issue_vld = 1'b0;
        check_state();
    endtask

    task automatic drive_read(input fu_pkg::fu_id_t fu, input rename_pkg::reg_id_t r0,
                              input rename_pkg::reg_id_t r1, input rename_pkg::reg_id_t nxt,
                              input logic rdy);
        logic ok;
        fu_read_vld[fu]      = 1'b1;
        fu_read_reg0[fu]     = r0;
        fu_read_reg1[fu]     = r1;
        fu_write_reg_nxt[fu] = nxt;
        rf_read_rdy[fu]      = rdy;
        #1;
        ok = (!m_pending[r0] || r0 == nxt) && (!m_pending[r1] || r1 == nxt);
        check_value($sformatf("rf_read_vld[%0d]", fu), 32'(ok), 32'(rf_read_vld[fu]));
        check_value($sformatf("fu_read_rdy[%0d]", fu), 32'(ok && rdy), 32'(fu_read_rdy[fu]));
    endtask

    task automatic wait_read_ready(input fu_pkg::fu_id_t fu, output int cycles);
        cycles = 0;
        while (!fu_read_rdy[fu] && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        assert (fu_read_rdy[fu]) else begin
            $display("%s: read on FU %0d still blocked after %0d cycles", test_name, fu, TIMEOUT);
            errors++;
        end
    endtask

    // The register file holds off the write for stall cycles before accepting it
    task automatic write_result(input fu_pkg::fu_id_t fu, input rename_pkg::reg_id_t r,
                                input int stall);
        fu_pkg::data_t data;
        int            cycles;
        data              = fu_pkg::data_t'($urandom);
        fu_write_vld[fu]  = 1'b1;
        fu_write_reg[fu]  = r;
        fu_write_data[fu] = data;
        rf_write_rdy[fu]  = 1'b0;
        for (int c = 0; c < stall; c++) begin
            #1;
            check_value("fu_write_rdy under back-pressure", 0, 32'(fu_write_rdy[fu]));
            next_cycle();
            check_state();
        end
        rf_write_rdy[fu] = 1'b1;
        #1;
        cycles = 0;
        while (!fu_write_rdy[fu] && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        assert (fu_write_rdy[fu]) else begin
            $display("%s: write on FU %0d never accepted", test_name, fu);
            errors++;
        end
        check_value("rf_write_vld", 1, 32'(rf_write_vld[fu]));
        check_value("rf_write_reg", 32'(r), 32'(rf_write_reg[fu]));
        check_value("rf_write_data", 32'(data), 32'(rf_write_data[fu]));
        @(posedge clk);
        m_pending[r] = 1'b0;
        #2;
        fu_write_vld[fu] = 1'b0;
        rf_write_rdy[fu] = 1'b0;
        check_state();
    endtask

    initial begin
        rand_init        = $urandom(32'h5309a4e0);
        rst_n            = 1'b0;
        fu_available     = '1;
        reg_read_pending = '0;
        issue_vld        = 1'b0;
        issue_fu         = '0;
        issue_dst_reg    = '0;
        issue_src_reg0   = '0;
        issue_src_reg1   = '0;
        fu_read_vld      = '0;
        fu_read_reg0     = '0;
        fu_read_reg1     = '0;
        fu_write_reg_nxt = '0;
        rf_read_rdy      = '0;
        fu_write_vld     = '0;
        fu_write_reg     = '0;
        fu_write_data    = '0;
        rf_write_rdy     = '0;
        m_map            = '{default: '0};
        m_pending        = '0;
        m_retired        = '1;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start_test("reset_state");
        check_state();
        check_value("cur_tag_map", 0, 32'(cur_tag_map));
        probe_issue(0, 0);
        check_value("issue_rdy for dst 0", 1, 32'(issue_rdy));
        fu_available = 4'b1011;
        probe_issue(2, 0);
        check_value("issue_rdy on unavailable FU", 0, 32'(issue_rdy));
        probe_issue(2, 1);
        fu_available = '1;
        finish_test();

        start_test("first_allocations");
        for (int t = 1; t < `SB_NUM_TAG; t++) begin
            issue_instr(fu_pkg::fu_id_t'(t), rename_pkg::tag_id_t'(t), got);
            check_value("lowest free register", t, 32'(got));
        end
        finish_test();

        start_test("no_reuse_while_pending");
        // register 4 is still being read by a reservation station
        reg_read_pending = 8'b0001_0000;
        for (int t = 1; t < `SB_NUM_TAG; t++) begin
            issue_instr(fu_pkg::fu_id_t'(t), rename_pkg::tag_id_t'(t), got);
            check_value("register past read-pending one", t + 4, 32'(got));
        end
        probe_issue(0, 1);
        check_value("issue_rdy with no free register", 0, 32'(issue_rdy));
        probe_issue(0, 0);
        check_value("issue_rdy for dst 0 when full", 1, 32'(issue_rdy));
        reg_read_pending = '0;
        issue_instr(0, 1, got);
        check_value("register after read release", 4, 32'(got));
        for (int t = 1; t < `SB_NUM_TAG; t++) begin
            probe_issue(fu_pkg::fu_id_t'(t), rename_pkg::tag_id_t'(t));
            check_value("issue_rdy with all pending", 0, 32'(issue_rdy));
        end
        issue_instr(2, 0, got);
        check_value("rename of dst 0", 0, 32'(got));
        finish_test();

        start_test("read_hazards");
        drive_read(1, 5, 0, 0, 1'b1);
        check_value("blocked rf_read_vld", 0, 32'(rf_read_vld[1]));
        drive_read(1, 5, 0, 5, 1'b1);
        check_value("own destination fu_read_rdy", 1, 32'(fu_read_rdy[1]));
        drive_read(1, 0, 0, 0, 1'b0);
        check_value("stalled fu_read_rdy", 0, 32'(fu_read_rdy[1]));
        drive_read(2, 3, 5, 3, 1'b1);
        fu_read_vld = '0;
        finish_test();

        start_test("write_back_release");
        drive_read(3, 6, 0, 0, 1'b1);
        write_result(0, 6, 0);
        wait_read_ready(3, waited);
        check_value("cycles until read release", 0, waited);
        drive_read(3, 6, 0, 0, 1'b1);
        fu_read_vld = '0;
        write_result(1, 7, 2);
        // Register 6 is idle and still the mapping of tag 2, so tag 2 may take it again
        issue_instr(2, 2, got);
        check_value("reuse of current mapping", 6, 32'(got));
        write_result(2, 1, 0);
        issue_instr(3, 3, got);
        check_value("register freed by write-back", 1, 32'(got));
        issue_instr(1, 1, got);
        check_value("old register of tag 3", 7, 32'(got));
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errors());
        if (total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* write_back.sv */
`include "sb_params.svh"

module write_back (
    input  fu_pkg::fu_mask_t                      fu_write_vld,
    output fu_pkg::fu_mask_t                      fu_write_rdy,
    input  rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  fu_write_reg,
    input  fu_pkg::data_t [`SB_NUM_FU-1:0]        fu_write_data,
    output fu_pkg::fu_mask_t                      rf_write_vld,
    input  fu_pkg::fu_mask_t                      rf_write_rdy,
    output rename_pkg::reg_id_t [`SB_NUM_FU-1:0]  rf_write_reg,
    output fu_pkg::data_t [`SB_NUM_FU-1:0]        rf_write_data,
    output rename_pkg::reg_mask_t                 wb_mask
);

    fu_pkg::fu_mask_t accepted;

    assign rf_write_vld  = fu_write_vld;
    assign rf_write_reg  = fu_write_reg;
    assign rf_write_data = fu_write_data;
    assign fu_write_rdy  = rf_write_rdy;

    assign accepted = fu_write_vld & rf_write_rdy;

    // Registers whose write completes this cycle, from all FUs together
    always_comb begin
        wb_mask = '0;
        for (int f = 0; f < `SB_NUM_FU; f++) begin
            if (accepted[f]) begin
                wb_mask = wb_mask | (rename_pkg::reg_mask_t'(1) << fu_write_reg[f]);
            end
        end
        // Register 0 is never pending
        wb_mask[0] = 1'b0;
    end

endmodule
